/* common/fp_add_defines.svh */
/*
 * Register map and widths of the adder peripheral
 * Addresses are byte offsets on a 4-bit AXI4-Lite address bus
 */

`ifndef FP_ADD_DEFINES_SVH
`define FP_ADD_DEFINES_SVH

// AXI4-Lite bus widths
`define FP_ADD_ADDR_W 4
`define FP_ADD_DATA_W 32

// Register offsets
`define FP_ADD_ADDR_OP_A   4'h0
`define FP_ADD_ADDR_OP_B   4'h4
`define FP_ADD_ADDR_RESULT 4'h8
`define FP_ADD_ADDR_STATUS 4'hC

// Number of register stages in the adder
`define FP_ADD_PIPE_DEPTH 3

`endif

/* common/fp_add_pkg.sv */
/*
 * Shared types for the single-precision adder peripheral
 * Only positive normal operands are modelled, no rounding, no NaN or infinity
 * Stage payloads carry a passthrough operand for the zero-operand case
 */

package fp_add_pkg;

  // IEEE 754 single-precision fields, sign in bit 31
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
  } float_t;

  // Operand pair written by the host, a is taken from OP_A
  typedef struct packed {
    float_t a;
    float_t b;
  } operands_t;

  // Stage 1 output after exponent ordering and alignment
  typedef struct packed {
    logic [23:0] small_sig;  // Smaller significand, already shifted right
    logic [23:0] big_sig;    // Larger significand with hidden one
    logic [7:0]  exp;        // Exponent of the larger operand
    float_t      pass;       // Operand returned as is when the other is zero
    logic        pass_en;
  } aligned_t;

  // Stage 2 output after significand addition
  typedef struct packed {
    logic        carry;
    logic [23:0] sig;
    logic [7:0]  exp;
    float_t      pass;
    logic        pass_en;
  } summed_t;

  // Final sum with its zero status
  typedef struct packed {
    float_t sum;
    logic   zero;  // Bits 30..0 of sum are all zero
  } result_t;

  // AXI response codes used by this slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* fp_adder/fp_add_pipe.sv */
/*
 * Three-stage adder for positive normal single-precision operands
 * Shifted-out bits are dropped, no rounding, carry out of exponent 254 is not caught
 * An operand with bits 30..0 at zero makes the other operand pass through unchanged
 */

`timescale 1ns/1ps

module fp_add_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fp_add_pkg::operands_t op,
  input  logic                  op_valid,
  output logic                  op_ready,
  output fp_add_pkg::result_t   res,
  output logic                  res_valid,
  input  logic                  res_ready,
  output logic                  busy
);

  // Stage 1 signals
  fp_add_pkg::float_t   small_op;
  fp_add_pkg::float_t   big_op;
  logic                 swap;
  logic                 a_zero;
  logic                 b_zero;
  fp_add_pkg::aligned_t align_d;
  fp_add_pkg::aligned_t align_q;
  logic                 align_valid;

  // Stage 2 signals
  logic                 add_ready;
  fp_add_pkg::summed_t  sum_d;
  fp_add_pkg::summed_t  sum_q;
  logic                 sum_valid;

  // Stage 3 signals
  logic                 norm_ready;
  logic [7:0]           norm_exp;
  logic [22:0]          norm_mant;
  fp_add_pkg::float_t   norm_sum;
  fp_add_pkg::result_t  norm_d;

  // Operand with the smaller exponent gets shifted
  assign swap     = op.a.exp > op.b.exp;
  assign small_op = swap ? op.b : op.a;
  assign big_op   = swap ? op.a : op.b;

  // Zero detection ignores the sign bit
  assign a_zero = {op.a.exp, op.a.mant} == 31'b0;
  assign b_zero = {op.b.exp, op.b.mant} == 31'b0;

  always_comb
  begin
    // Right shift by the exponent difference, large differences flush to zero
    align_d.small_sig = {1'b1, small_op.mant} >> (big_op.exp - small_op.exp);
    align_d.big_sig   = {1'b1, big_op.mant};
    align_d.exp       = big_op.exp;
    // b is returned when a is zero, a when only b is zero
    align_d.pass      = a_zero ? op.b : op.a;
    align_d.pass_en   = a_zero | b_zero;
  end

  pipe_stage #(
    .payload_t (fp_add_pkg::aligned_t)
  ) i_align_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (align_d),
    .in_valid  (op_valid),
    .in_ready  (op_ready),
    .out       (align_q),
    .out_valid (align_valid),
    .out_ready (add_ready)
  );

  always_comb
  begin
    // 25-bit sum keeps the carry of the two 24-bit significands
    {sum_d.carry, sum_d.sig} = {1'b0, align_q.small_sig} + {1'b0, align_q.big_sig};
    sum_d.exp                = align_q.exp;
    sum_d.pass               = align_q.pass;
    sum_d.pass_en            = align_q.pass_en;
  end

  pipe_stage #(
    .payload_t (fp_add_pkg::summed_t)
  ) i_add_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (sum_d),
    .in_valid  (align_valid),
    .in_ready  (add_ready),
    .out       (sum_q),
    .out_valid (sum_valid),
    .out_ready (norm_ready)
  );

  // Renormalize by one place on carry, the hidden one drops off the top
  always_comb
  begin
    if (sum_q.carry)
    begin
      norm_exp  = sum_q.exp + 8'd1;
      norm_mant = sum_q.sig[23:1];
    end
    else
    begin
      norm_exp  = sum_q.exp;
      norm_mant = sum_q.sig[22:0];
    end
  end

  // A calculated sum is always positive
  assign norm_sum = sum_q.pass_en ? sum_q.pass : {1'b0, norm_exp, norm_mant};

  assign norm_d.sum  = norm_sum;
  assign norm_d.zero = {norm_sum.exp, norm_sum.mant} == 31'b0;

  pipe_stage #(
    .payload_t (fp_add_pkg::result_t)
  ) i_norm_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (norm_d),
    .in_valid  (sum_valid),
    .in_ready  (norm_ready),
    .out       (res),
    .out_valid (res_valid),
    .out_ready (res_ready)
  );

  // Any occupied stage means work in flight
  assign busy = align_valid | sum_valid | res_valid;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the adder peripheral testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module fp_add_tb -o fp_add_sim

./obj_dir/fp_add_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"

/* src/fp_add_top.sv */
/*
 * Adder peripheral top, AXI4-Lite slave in front of the adder pipeline
 * Status shows a new sum 4 cycles after an unstalled OP_B write
 */

`timescale 1ns/1ps
`include "fp_add_defines.svh"

module fp_add_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`FP_ADD_ADDR_W-1:0]    awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`FP_ADD_DATA_W-1:0]    wdata,
  input  logic [`FP_ADD_DATA_W/8-1:0]  wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output fp_add_pkg::axi_resp_e        bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`FP_ADD_ADDR_W-1:0]    araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [`FP_ADD_DATA_W-1:0]    rdata,
  output fp_add_pkg::axi_resp_e        rresp,
  output logic                         rvalid,
  input  logic                         rready
);

  // Operand stream into the adder
  fp_add_pkg::operands_t op;
  logic                  op_valid;
  logic                  op_ready;

  // Result stream back to the register file
  fp_add_pkg::result_t   res;
  logic                  res_valid;
  logic                  res_ready;
  logic                  busy;

  fp_axil_regs i_fp_axil_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .op        (op),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .busy      (busy)
  );

  fp_add_pipe i_fp_add_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .op        (op),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .busy      (busy)
  );

endmodule

/* src/fp_axil_regs.sv */
/*
 * AXI4-Lite register front end of the adder, WSTRB is ignored
 * One write and one read in flight, OP_B write response waits for the issue
 * Single-entry result buffer, a RESULT read on an empty buffer gives SLVERR
 */

`timescale 1ns/1ps
`include "fp_add_defines.svh"

module fp_axil_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`FP_ADD_ADDR_W-1:0]    awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`FP_ADD_DATA_W-1:0]    wdata,
  input  logic [`FP_ADD_DATA_W/8-1:0]  wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output fp_add_pkg::axi_resp_e        bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`FP_ADD_ADDR_W-1:0]    araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [`FP_ADD_DATA_W-1:0]    rdata,
  output fp_add_pkg::axi_resp_e        rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output fp_add_pkg::operands_t        op,
  output logic                         op_valid,
  input  logic                         op_ready,
  input  fp_add_pkg::result_t          res,
  input  logic                         res_valid,
  output logic                         res_ready,
  input  logic                         busy
);

  logic                      aw_held;
  logic                      w_held;
  logic [`FP_ADD_ADDR_W-1:0] aw_addr_q;
  logic [`FP_ADD_DATA_W-1:0] w_data_q;
  logic                      wr_block;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      wr_fire;
  logic [`FP_ADD_ADDR_W-1:0] wr_addr;
  logic [`FP_ADD_DATA_W-1:0] wr_data;
  logic                      issue_hs;
  logic                      ar_hs;
  logic                      rd_pop;
  fp_add_pkg::float_t        op_a;
  fp_add_pkg::float_t        op_b;
  fp_add_pkg::result_t       res_buf;
  logic                      res_buf_valid;

  // No new write while a response or an issue is outstanding
  assign wr_block = bvalid | op_valid;
  assign awready  = !aw_held && !wr_block;
  assign wready   = !w_held && !wr_block;
  assign aw_hs    = awvalid && awready;
  assign w_hs     = wvalid && wready;

  // Address and data may arrive in either order
  assign wr_fire  = (aw_held || aw_hs) && (w_held || w_hs);
  assign wr_addr  = aw_held ? aw_addr_q : awaddr;
  assign wr_data  = w_held ? w_data_q : wdata;
  assign issue_hs = op_valid && op_ready;

  assign op = '{a: op_a, b: op_b};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      aw_addr_q <= '0;
      w_data_q  <= '0;
      op_a      <= '0;
      op_b      <= '0;
      op_valid  <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= fp_add_pkg::OKAY;
    end
    else
    begin
      // Park whichever half came first
      if (wr_fire)
        aw_held <= 1'b0;
      else if (aw_hs)
      begin
        aw_held   <= 1'b1;
        aw_addr_q <= awaddr;
      end

      if (wr_fire)
        w_held <= 1'b0;
      else if (w_hs)
      begin
        w_held   <= 1'b1;
        w_data_q <= wdata;
      end

      if (wr_fire)
      begin
        case (wr_addr)
          `FP_ADD_ADDR_OP_A:
          begin
            op_a   <= fp_add_pkg::float_t'(wr_data);
            bvalid <= 1'b1;
            bresp  <= fp_add_pkg::OKAY;
          end
          // Response deferred until the pipe takes the operands
          `FP_ADD_ADDR_OP_B:
          begin
            op_b     <= fp_add_pkg::float_t'(wr_data);
            op_valid <= 1'b1;
          end
          // RESULT and STATUS are read-only
          default:
          begin
            bvalid <= 1'b1;
            bresp  <= fp_add_pkg::SLVERR;
          end
        endcase
      end

      if (issue_hs)
      begin
        op_valid <= 1'b0;
        bvalid   <= 1'b1;
        bresp    <= fp_add_pkg::OKAY;
      end

      if (bvalid && bready)
        bvalid <= 1'b0;
    end
  end

  // One read response at a time
  assign arready = !rvalid;
  assign ar_hs   = arvalid && arready;
  assign rd_pop  = ar_hs && (araddr == `FP_ADD_ADDR_RESULT) && res_buf_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= fp_add_pkg::OKAY;
    end
    else if (ar_hs)
    begin
      rvalid <= 1'b1;
      rresp  <= fp_add_pkg::OKAY;
      case (araddr)
        `FP_ADD_ADDR_OP_A:   rdata <= op_a;
        `FP_ADD_ADDR_OP_B:   rdata <= op_b;
        `FP_ADD_ADDR_RESULT:
        begin
          rdata <= res_buf_valid ? res_buf.sum : '0;
          if (!res_buf_valid)
            rresp <= fp_add_pkg::SLVERR;
        end
        // Bit 0 result_valid, bit 1 zero, bit 2 busy
        `FP_ADD_ADDR_STATUS:
          rdata <= {{(`FP_ADD_DATA_W-3){1'b0}}, busy,
                    res_buf_valid & res_buf.zero, res_buf_valid};
        default:
        begin
          rdata <= '0;
          rresp <= fp_add_pkg::SLVERR;
        end
      endcase
    end
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // Result buffer accepts only when empty
  assign res_ready = !res_buf_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      res_buf       <= '0;
      res_buf_valid <= 1'b0;
    end
    else if (res_valid && res_ready)
    begin
      res_buf       <= res;
      res_buf_valid <= 1'b1;
    end
    else if (rd_pop)
      res_buf_valid <= 1'b0;
  end

endmodule

/* src/pipe_stage.sv */
/*
 * Elastic pipeline register, one cycle latency, full throughput
 * in_ready looks at out_ready combinationally, out_valid never depends on ready
 */

`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  // Room when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (in_ready)
      out_valid <= in_valid;
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
      out <= in;
  end

endmodule

/* tb.f */
+incdir+common
common/fp_add_pkg.sv
src/pipe_stage.sv
fp_adder/fp_add_pipe.sv
src/fp_axil_regs.sv
src/fp_add_top.sv
verif/tb_clk_gen.sv
verif/fp_add_sva.sv
verif/fp_add_tb.sv

/* verif/fp_add_sva.sv */
/*
 * Handshake checks for one valid/ready stream, bound into the pipe and the registers
 * in_fire marks an item entering, out_valid/out_ready the stream leaving
 * reset_low holds valids that must be low on the first edge after reset
 */

`timescale 1ns/1ps
`include "fp_add_defines.svh"

module fp_add_sva #(
  parameter int W = 32
) (
  input logic         clk,
  input logic         rst_n,
  input logic         in_fire,
  input logic         out_valid,
  input logic         out_ready,
  input logic [W-1:0] out_data,
  input logic [1:0]   reset_low
);

  // Items accepted but not yet handed on
  int unsigned pending;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pending <= 0;
    else if (in_fire && !(out_valid && out_ready))
      pending <= pending + 1;
    else if (!in_fire && out_valid && out_ready)
      pending <= pending - 1;
  end

  // A stalled item keeps valid up
  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("valid dropped while stalled");

  // and keeps its payload
  data_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_data))
    else $error("payload changed while stalled");

  // Nothing comes out that never went in
  no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> pending != 0)
    else $error("valid without an earlier input transfer");

  idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> reset_low == 2'b00)
    else $error("valid high right after reset");

endmodule

// Pipe: operands in, results out
bind fp_add_pipe fp_add_sva #(
  .W ($bits(fp_add_pkg::result_t))
) i_pipe_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_fire   (op_valid && op_ready),
  .out_valid (res_valid),
  .out_ready (res_ready),
  .out_data  (res),
  .reset_low ({res_valid, busy})
);

// Registers: an OP_B write produces one issue
bind fp_axil_regs fp_add_sva #(
  .W ($bits(fp_add_pkg::operands_t))
) i_regs_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_fire   (wr_fire && (wr_addr == `FP_ADD_ADDR_OP_B)),
  .out_valid (op_valid),
  .out_ready (op_ready),
  .out_data  (op),
  .reset_low ({bvalid, rvalid})
);

/* verif/fp_add_tb.sv */
/*
 * Testbench for the adder peripheral, AXI4-Lite master driven on the falling edge
 * Expected sums come from a truncating model of positive normal addition
 * One AXI write and one AXI read can run at a time, in separate processes
 */

`timescale 1ns/1ps
`include "fp_add_defines.svh"

module fp_add_tb;

  localparam int N_DIRECTED      = 14;
  localparam int N_RANDOM        = 40;
  localparam int N_BACKPRESSURE  = `FP_ADD_PIPE_DEPTH + 2;
  localparam int N_OPS           = N_DIRECTED + N_RANDOM + N_BACKPRESSURE + 8;
  localparam int WATCHDOG_CYCLES = N_OPS * 200;
  localparam int POLL_LIMIT      = 16;

  typedef struct packed {
    fp_add_pkg::float_t a;
    fp_add_pkg::float_t b;
    fp_add_pkg::float_t sum;
  } vector_t;

  // Columns: operand a, operand b, expected sum
  localparam logic [95:0] VECTORS [N_DIRECTED] = '{
    {32'h3F800000, 32'h3F800000, 32'h40000000},  // 1.0 + 1.0, carry
    {32'h3FC00000, 32'h40100000, 32'h40700000},  // 1.5 + 2.25
    {32'h40000000, 32'h40400000, 32'h40A00000},  // 2.0 + 3.0, carry
    {32'h3F000000, 32'h3E800000, 32'h3F400000},  // 0.5 + 0.25
    {32'h41200000, 32'h3F000000, 32'h41280000},  // 10.0 + 0.5
    {32'h3F800000, 32'h33800000, 32'h3F800000},  // Small operand shifted out
    {32'h3FE00000, 32'h3FE00000, 32'h40600000},  // 1.75 + 1.75, carry
    {32'h3F800000, 32'h3F800001, 32'h40000000},  // Carry drops the low bit
    {32'h7F000000, 32'h3F800000, 32'h7F000000},  // Largest exponent
    {32'h00000000, 32'h3FC00000, 32'h3FC00000},  // Zero + x
    {32'h3FC00000, 32'h00000000, 32'h3FC00000},  // x + zero
    {32'h80000000, 32'h40100000, 32'h40100000},  // Negative zero counts as zero
    {32'h00000000, 32'hC0000000, 32'hC0000000},  // Passthrough keeps the sign
    {32'h00000000, 32'h00000000, 32'h00000000}   // Zero + zero
  };

  logic                          clk;
  logic                          rst_n;
  logic [`FP_ADD_ADDR_W-1:0]     awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [`FP_ADD_DATA_W-1:0]     wdata;
  logic [`FP_ADD_DATA_W/8-1:0]   wstrb;
  logic                          wvalid;
  logic                          wready;
  fp_add_pkg::axi_resp_e         bresp;
  logic                          bvalid;
  logic                          bready;
  logic [`FP_ADD_ADDR_W-1:0]     araddr;
  logic                          arvalid;
  logic                          arready;
  logic [`FP_ADD_DATA_W-1:0]     rdata;
  fp_add_pkg::axi_resp_e         rresp;
  logic                          rvalid;
  logic                          rready;

  int                            value_errors;
  int                            resp_errors;
  int                            flow_errors;
  logic [31:0]                   lcg_state;
  fp_add_pkg::float_t            expect_q[$];
  logic                          last_done;
  fp_add_pkg::axi_resp_e         last_resp;

  tb_clk_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (10)
  ) i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fp_add_top i_fp_add_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Positive normal addition with truncation, zero operand passes the other one
  function automatic fp_add_pkg::float_t add_model(input fp_add_pkg::float_t a,
                                                   input fp_add_pkg::float_t b);
    fp_add_pkg::float_t hi;
    fp_add_pkg::float_t lo;
    fp_add_pkg::float_t r;
    logic [7:0]         diff;
    logic [23:0]        lo_sig;
    logic [24:0]        total;
    if ({a.exp, a.mant} == 31'd0)
      return b;
    if ({b.exp, b.mant} == 31'd0)
      return a;
    if (a.exp >= b.exp)
    begin
      hi = a;
      lo = b;
    end
    else
    begin
      hi = b;
      lo = a;
    end
    diff   = hi.exp - lo.exp;
    lo_sig = (diff > 8'd23) ? 24'd0 : ({1'b1, lo.mant} >> diff);
    total  = {1'b0, lo_sig} + {2'b01, hi.mant};
    r.sign = 1'b0;
    if (total[24])
    begin
      r.exp  = hi.exp + 8'd1;
      r.mant = total[23:1];
    end
    else
    begin
      r.exp  = hi.exp;
      r.mant = total[22:0];
    end
    return r;
  endfunction

  task automatic check_sum(input string what, input fp_add_pkg::float_t got,
                           input fp_add_pkg::float_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL %0d ns: %s sum got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input fp_add_pkg::axi_resp_e got,
                            input fp_add_pkg::axi_resp_e exp);
    if (got !== exp)
    begin
      resp_errors++;
      $display("FAIL %0d ns: %s response got %s expected %s", $time, what,
               got.name(), exp.name());
    end
  endtask

  task automatic check_word(input string what, input logic [`FP_ADD_DATA_W-1:0] got,
                            input logic [`FP_ADD_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("FAIL %0d ns: %s data got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Ready is sampled mid-cycle, the transfer happens on the next rising edge
  task automatic axi_write(input logic [`FP_ADD_ADDR_W-1:0] addr,
                           input logic [`FP_ADD_DATA_W-1:0] data,
                           output fp_add_pkg::axi_resp_e resp);
    logic aw_go;
    logic w_go;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = '1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid)
    begin
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      @(negedge clk);
      if (aw_go)
        awvalid = 1'b0;
      if (w_go)
        wvalid = 1'b0;
    end
    while (!bvalid)
      @(negedge clk);
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`FP_ADD_ADDR_W-1:0] addr,
                          output logic [`FP_ADD_DATA_W-1:0] data,
                          output fp_add_pkg::axi_resp_e resp);
    logic ar_go;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    ar_go   = 1'b0;
    while (!ar_go)
    begin
      ar_go = arready;
      @(negedge clk);
    end
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Poll STATUS until result_valid, bounded
  task automatic wait_result(output logic [`FP_ADD_DATA_W-1:0] status);
    int                    polls;
    fp_add_pkg::axi_resp_e resp;
    polls  = 0;
    status = '0;
    while (!status[0] && polls < POLL_LIMIT)
    begin
      axi_read(`FP_ADD_ADDR_STATUS, status, resp);
      polls++;
    end
    if (!status[0])
    begin
      flow_errors++;
      $display("No result became ready after %0d STATUS reads", polls);
    end
  endtask

  task automatic run_add(input fp_add_pkg::float_t a, input fp_add_pkg::float_t b,
                         output fp_add_pkg::float_t sum,
                         output logic [`FP_ADD_DATA_W-1:0] status);
    fp_add_pkg::axi_resp_e     resp;
    logic [`FP_ADD_DATA_W-1:0] data;
    axi_write(`FP_ADD_ADDR_OP_A, a, resp);
    check_resp("OP_A write", resp, fp_add_pkg::OKAY);
    axi_write(`FP_ADD_ADDR_OP_B, b, resp);
    check_resp("OP_B write", resp, fp_add_pkg::OKAY);
    wait_result(status);
    axi_read(`FP_ADD_ADDR_RESULT, data, resp);
    check_resp("RESULT read", resp, fp_add_pkg::OKAY);
    sum = fp_add_pkg::float_t'(data);
  endtask

  // Pops the oldest expected sum
  task automatic read_next_result(input string what);
    logic [`FP_ADD_DATA_W-1:0] status;
    logic [`FP_ADD_DATA_W-1:0] data;
    fp_add_pkg::axi_resp_e     resp;
    wait_result(status);
    axi_read(`FP_ADD_ADDR_RESULT, data, resp);
    check_resp(what, resp, fp_add_pkg::OKAY);
    check_sum(what, fp_add_pkg::float_t'(data), expect_q.pop_front());
  endtask

  // Exponents stay in 1..253 so a carry cannot overflow
  task automatic random_operands(output fp_add_pkg::float_t a,
                                 output fp_add_pkg::float_t b);
    logic [7:0] spread;
    lcg_state = lcg_next(lcg_state);
    a.sign    = 1'b0;
    a.exp     = 8'd1 + (lcg_state[31:24] % 8'd253);
    lcg_state = lcg_next(lcg_state);
    a.mant    = lcg_state[30:8];
    lcg_state = lcg_next(lcg_state);
    spread    = {3'b000, lcg_state[31:27]};
    b.sign    = 1'b0;
    b.exp     = (a.exp > spread) ? a.exp - spread : a.exp + spread;
    lcg_state = lcg_next(lcg_state);
    b.mant    = lcg_state[30:8];
  endtask

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests finished",
             WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    vector_t                   vec;
    fp_add_pkg::float_t        a;
    fp_add_pkg::float_t        b;
    fp_add_pkg::float_t        got;
    fp_add_pkg::axi_resp_e     resp;
    logic [`FP_ADD_DATA_W-1:0] status;
    logic [`FP_ADD_DATA_W-1:0] data;
    logic                      zero_exp;

    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    value_errors = 0;
    resp_errors  = 0;
    flow_errors  = 0;
    last_done    = 1'b0;
    last_resp    = fp_add_pkg::OKAY;
    lcg_state    = 32'hcaeea5d1;

    wait (rst_n === 1'b1);

    // State right after reset and error responses
    axi_read(`FP_ADD_ADDR_STATUS, data, resp);
    check_resp("STATUS after reset", resp, fp_add_pkg::OKAY);
    check_word("STATUS after reset", data, '0);
    axi_read(`FP_ADD_ADDR_RESULT, data, resp);
    check_resp("RESULT on empty buffer", resp, fp_add_pkg::SLVERR);
    check_word("RESULT on empty buffer", data, '0);
    axi_read(4'h2, data, resp);
    check_resp("unmapped read", resp, fp_add_pkg::SLVERR);
    axi_write(`FP_ADD_ADDR_STATUS, 32'h1, resp);
    check_resp("STATUS write", resp, fp_add_pkg::SLVERR);

    // Directed table with zero operands
    for (int i = 0; i < N_DIRECTED; i++)
    begin
      vec = vector_t'(VECTORS[i]);
      run_add(vec.a, vec.b, got, status);
      check_sum($sformatf("vector %0d against table", i), got, vec.sum);
      check_sum($sformatf("vector %0d against model", i), got, add_model(vec.a, vec.b));
      zero_exp = {vec.sum.exp, vec.sum.mant} == 31'd0;
      check_word($sformatf("vector %0d STATUS", i), status, {29'd0, 1'b0, zero_exp, 1'b1});
    end

    // Random positive normals
    for (int i = 0; i < N_RANDOM; i++)
    begin
      random_operands(a, b);
      run_add(a, b, got, status);
      check_sum($sformatf("random %0d", i), got, add_model(a, b));
    end

    // Fill the buffer and all stages, the last issue has to wait
    for (int i = 0; i < N_BACKPRESSURE; i++)
    begin
      random_operands(a, b);
      expect_q.push_back(add_model(a, b));
      axi_write(`FP_ADD_ADDR_OP_A, a, resp);
      check_resp("backpressure OP_A", resp, fp_add_pkg::OKAY);
      if (i < N_BACKPRESSURE - 1)
      begin
        axi_write(`FP_ADD_ADDR_OP_B, b, resp);
        check_resp("backpressure OP_B", resp, fp_add_pkg::OKAY);
      end
      else
      begin
        last_done = 1'b0;
        fork
          begin
            axi_write(`FP_ADD_ADDR_OP_B, b, last_resp);
            last_done = 1'b1;
          end
          begin
            repeat (4 * `FP_ADD_PIPE_DEPTH) @(negedge clk);
            if (last_done)
            begin
              flow_errors++;
              $display("OP_B write was answered while the pipeline was full");
            end
            // Buffer holds a nonzero sum and every stage is occupied
            axi_read(`FP_ADD_ADDR_STATUS, data, resp);
            check_resp("STATUS with full pipeline", resp, fp_add_pkg::OKAY);
            check_word("STATUS with full pipeline", data, 32'h5);
            read_next_result("backpressure result 0");
          end
        join
        check_resp("backpressure last OP_B", last_resp, fp_add_pkg::OKAY);
      end
    end
    for (int i = 1; i < N_BACKPRESSURE; i++)
      read_next_result($sformatf("backpressure result %0d", i));

    // OP_A readback and a drained buffer
    axi_write(`FP_ADD_ADDR_OP_A, 32'h40490FDB, resp);
    check_resp("OP_A write", resp, fp_add_pkg::OKAY);
    axi_read(`FP_ADD_ADDR_OP_A, data, resp);
    check_resp("OP_A readback", resp, fp_add_pkg::OKAY);
    check_word("OP_A readback", data, 32'h40490FDB);
    axi_read(`FP_ADD_ADDR_RESULT, data, resp);
    check_resp("RESULT after drain", resp, fp_add_pkg::SLVERR);

    $display("Errors: %0d value, %0d response, %0d flow",
             value_errors, resp_errors, flow_errors);
    if (value_errors + resp_errors + flow_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
/*
 * Testbench clock and reset source
 * rst_n is released on a falling edge after RESET_CYCLES rising edges
 */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release away from the rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
